//--- ramio.f
+incdir+hw
hw/ramio_pkg.sv
hw/lane_align.sv
hw/word_ram.sv
hw/io_regs.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/ramio.sv
testbench/clock_gen.sv
testbench/tb_ramio.sv

//--- run_sim.sh
#!/bin/sh
# build and run the ramio testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f ramio.f --top-module tb_ramio -o sim_ramio

# a failing run exits nonzero, the log decides the result
./obj_dir/sim_ramio > sim.log 2>&1 || true
cat sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -qF '** PASS **' sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi
echo "simulation passed"

//--- testbench/tb_ramio.sv
//----------------------------------------------------------------------
// testbench for the ramio bridge
// drives load/store requests, keeps a word model of the RAM and
// checks every answered load; UART pins are looped back
//----------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

module tb_ramio;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int MAX_CYCLES = 20000;
  localparam int NUM_WORDS  = 32;
  localparam int RAM_WORDS  = 2 ** `RAMIO_RAM_ADDR_BITS;
  localparam logic [3:0] LED_PATTERNS [4] = '{4'b1010, 4'b0101, 4'b0000, 4'b1111};

  logic                clk;
  logic                rst_n;
  logic                enable;
  ramio_pkg::mem_req_t req;
  ramio_pkg::word_t    data_out;
  logic                data_out_ready;
  logic [3:0]          led;
  // serial loopback, every sent byte comes back in
  wire                 uart_line;

  // expected answer of the load in flight
  logic                chk_load;
  logic                chk_alt;
  ramio_pkg::word_t    exp_data;
  ramio_pkg::word_t    alt_data;
  ramio_pkg::word_t    last_data;

  // reference model of the RAM
  ramio_pkg::word_t    model_mem [RAM_WORDS];
  ramio_pkg::addr_t    stored [$];
  int                  seed = 32'he39b;
  int                  cycles = 0;

  clock_gen u_clk (
    .clk,
    .rst_n
  );

  ramio uut (
    .clk,
    .rst_n,
    .enable,
    .req,
    .data_out,
    .data_out_ready,
    .led,
    .uart_tx (uart_line),
    .uart_rx (uart_line)
  );

  task automatic stop_on_error(input string line);
    $display("%s", line);
    $display("** FAIL **");
    $fatal(1, "simulation stopped");
  endtask

  //--------------------------------------------------------------------
  // reference model
  //--------------------------------------------------------------------
  function automatic logic is_io_addr(input ramio_pkg::addr_t a);
    return a == `RAMIO_ADDR_LED || a == `RAMIO_ADDR_UART_OUT || a == `RAMIO_ADDR_UART_IN;
  endfunction

  // RAM byte address from a random word index and a lane offset
  function automatic ramio_pkg::addr_t ram_addr(input int r, input logic [1:0] off);
    ramio_pkg::addr_t a;
    a = '0;
    a[`RAMIO_RAM_ADDR_BITS+1:2] = r[`RAMIO_RAM_ADDR_BITS-1:0];
    a[1:0] = off;
    return a;
  endfunction

  function automatic void model_store(input ramio_pkg::access_size_e sz,
                                      input ramio_pkg::addr_t a, input ramio_pkg::word_t d);
    ramio_pkg::ram_index_t i;
    i = a[`RAMIO_RAM_ADDR_BITS+1:2];
    case (sz)
      ramio_pkg::size_byte: model_mem[i][8*a[1:0] +: 8] = d[7:0];
      // odd half address writes nothing
      ramio_pkg::size_half: if (!a[0]) model_mem[i][16*a[1] +: 16] = d[15:0];
      ramio_pkg::size_word: model_mem[i] = d;
      default: ;
    endcase
  endfunction

  function automatic ramio_pkg::word_t expect_load(input ramio_pkg::access_size_e sz,
                                                   input logic sgn, input ramio_pkg::addr_t a);
    ramio_pkg::word_t w;
    ramio_pkg::byte_t b;
    logic [15:0]      h;
    w = model_mem[a[`RAMIO_RAM_ADDR_BITS+1:2]];
    b = w[8*a[1:0] +: 8];
    h = w[16*a[1] +: 16];
    case (sz)
      ramio_pkg::size_byte: return {{24{sgn && b[7]}}, b};
      ramio_pkg::size_half: return a[0] ? 32'h0 : {{16{sgn && h[15]}}, h};
      default: return w;
    endcase
  endfunction

  //--------------------------------------------------------------------
  // request driver
  //--------------------------------------------------------------------
  // hold the request until data_out_ready, then one idle cycle
  task automatic run_request(input ramio_pkg::access_size_e ld, input logic sgn,
                             input ramio_pkg::access_size_e st, input ramio_pkg::addr_t a,
                             input ramio_pkg::word_t d);
    int waited;
    int want;
    // I/O answers in the same cycle, RAM one cycle later
    want = is_io_addr(a) ? 1 : 2;
    waited = 0;
    req.load.sign = sgn;
    req.load.size = ld;
    req.store     = st;
    req.addr      = a;
    req.data      = d;
    enable        = 1'b1;
    do begin
      @(negedge clk);
      waited++;
    end while (!data_out_ready);
    last_data = data_out;
    latency_check: assert (waited == want)
      else stop_on_error($sformatf("ERROR at %0t: request to %h ready after %0d cycles, want %0d",
                                   $time, a, waited, want));
    @(posedge clk);
    #1;
    enable   = 1'b0;
    chk_load = 1'b0;
    chk_alt  = 1'b0;
    // lets the RAM ready flag fall before the next request
    @(posedge clk);
    #1;
  endtask

  task automatic store(input ramio_pkg::access_size_e sz, input ramio_pkg::addr_t a,
                       input ramio_pkg::word_t d);
    chk_load = 1'b0;
    run_request(ramio_pkg::size_none, 1'b0, sz, a, d);
    if (!is_io_addr(a)) begin
      model_store(sz, a, d);
    end
  endtask

  task automatic load_expect(input ramio_pkg::access_size_e sz, input logic sgn,
                             input ramio_pkg::addr_t a, input ramio_pkg::word_t want);
    exp_data = want;
    chk_load = 1'b1;
    run_request(sz, sgn, ramio_pkg::size_none, a, '0);
  endtask

  task automatic load_ram(input ramio_pkg::access_size_e sz, input logic sgn,
                          input ramio_pkg::addr_t a);
    load_expect(sz, sgn, a, expect_load(sz, sgn, a));
  endtask

  // reload until want shows up, other is the only value allowed meanwhile
  task automatic poll_until(input ramio_pkg::addr_t a, input ramio_pkg::word_t want,
                            input ramio_pkg::word_t other);
    do begin
      alt_data = other;
      chk_alt  = 1'b1;
      load_expect(ramio_pkg::size_word, 1'b0, a, want);
    end while (last_data != want);
  endtask

  task automatic check_led(input logic [3:0] want);
    led_check: assert (led === want)
      else stop_on_error($sformatf("ERROR at %0t: led is %b, expected %b", $time, led, want));
  endtask

  //--------------------------------------------------------------------
  // checks on every answered load
  //--------------------------------------------------------------------
  property load_data_matches;
    @(posedge clk) disable iff (!rst_n)
      (enable && chk_load && data_out_ready) |->
        (data_out == exp_data || (chk_alt && data_out == alt_data));
  endproperty

  load_data_check: assert property (load_data_matches)
    else stop_on_error($sformatf("ERROR at %0t: load of %h returned %h, expected %h",
                                 $time, $sampled(req.addr), $sampled(data_out),
                                 $sampled(exp_data)));

  // run limit
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      stop_on_error($sformatf("timeout: no result after %0d clock cycles", MAX_CYCLES));
    end
  end

  //--------------------------------------------------------------------
  // stimulus
  //--------------------------------------------------------------------
  initial begin
    ramio_pkg::addr_t a;
    ramio_pkg::addr_t base;
    ramio_pkg::word_t d;
    enable    = 1'b0;
    req       = '0;
    chk_load  = 1'b0;
    chk_alt   = 1'b0;
    exp_data  = '0;
    alt_data  = '0;
    last_data = '0;
    wait (rst_n === 1'b1);

    // reset state, both mailboxes empty
    check_led(4'b1111);
    load_expect(ramio_pkg::size_word, 1'b0, `RAMIO_ADDR_UART_OUT, '1);
    load_expect(ramio_pkg::size_word, 1'b0, `RAMIO_ADDR_UART_IN, '1);

    // random words, then read them all back
    for (int i = 0; i < NUM_WORDS; i++) begin
      a = ram_addr($random(seed), 2'd0);
      store(ramio_pkg::size_word, a, $random(seed));
      stored.push_back(a);
    end
    foreach (stored[i]) begin
      load_ram(ramio_pkg::size_word, 1'b0, stored[i]);
    end

    // byte and half lanes, odd half offsets included
    for (int w = 0; w < 4; w++) begin
      base = ram_addr($random(seed), 2'd0);
      store(ramio_pkg::size_word, base, $random(seed));
      for (int off = 0; off < 4; off++) begin
        a = base | ramio_pkg::addr_t'(off);
        store(ramio_pkg::size_byte, a, $random(seed));
        load_ram(ramio_pkg::size_word, 1'b0, base);
        load_ram(ramio_pkg::size_byte, 1'b0, a);
        load_ram(ramio_pkg::size_byte, 1'b1, a);
        store(ramio_pkg::size_half, a, $random(seed));
        load_ram(ramio_pkg::size_word, 1'b0, base);
        load_ram(ramio_pkg::size_half, 1'b0, a);
        load_ram(ramio_pkg::size_half, 1'b1, a);
      end
    end

    // LED nibble, the register itself reads as zero
    foreach (LED_PATTERNS[k]) begin
      d = $random(seed);
      d[3:0] = LED_PATTERNS[k];
      store(ramio_pkg::size_word, `RAMIO_ADDR_LED, d);
      check_led(LED_PATTERNS[k]);
    end
    load_expect(ramio_pkg::size_word, 1'b0, `RAMIO_ADDR_LED, '0);

    // three frames out through the transmitter and back in
    for (int f = 0; f < 3; f++) begin
      d = $random(seed);
      store(ramio_pkg::size_byte, `RAMIO_ADDR_UART_OUT, d);
      load_expect(ramio_pkg::size_word, 1'b0, `RAMIO_ADDR_UART_OUT, {24'h0, d[7:0]});
      poll_until(`RAMIO_ADDR_UART_OUT, '1, {24'h0, d[7:0]});
      poll_until(`RAMIO_ADDR_UART_IN, {24'h0, d[7:0]}, '1);
      // mailbox empties after the read
      load_expect(ramio_pkg::size_word, 1'b0, `RAMIO_ADDR_UART_IN, '1);
    end

    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/clock_gen.sv
//----------------------------------------------------------------------
// clock and reset source for the ramio testbench
// 40 ns clock, rst_n held low over the first three rising edges
//----------------------------------------------------------------------
`default_nettype none

module clock_gen (
  output logic clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  localparam int HALF_PERIOD  = 20;
  localparam int RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  // release 1 ns after an edge, in step with the stimulus
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- hw/ramio.sv
//--------------------------------------------------------------------
// memory-mapped bridge from a processor load/store port to an
// on-chip word RAM, four LEDs and a UART
// the client holds req and enable until data_out_ready is high
//--------------------------------------------------------------------
`default_nettype none

module ramio (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  enable,
  input  wire ramio_pkg::mem_req_t req,
  output ramio_pkg::word_t     data_out,
  output logic                 data_out_ready,
  output logic [3:0]           led,
  output logic                 uart_tx,
  input  wire                  uart_rx
);

  // RAM side of the alignment unit
  ramio_pkg::ram_req_t ram;
  ramio_pkg::word_t    rdata;
  logic                rready;

  // decoded I/O strobes and the store byte
  logic                led_we;
  logic                tx_we;
  logic                rx_re;
  ramio_pkg::byte_t    wbyte;

  // I/O register contents shown to loads
  logic [3:0]          led_value;
  ramio_pkg::word_t    tx_word;
  ramio_pkg::word_t    rx_word;

  // UART handshakes
  logic                tx_go;
  logic                tx_bsy;
  ramio_pkg::byte_t    tx_byte;
  logic                rx_go;
  logic                rx_ready;
  ramio_pkg::byte_t    rx_data;

  lane_align u_align (
    .enable,
    .req,
    .ram,
    .rdata,
    .rready,
    .led_we,
    .tx_we,
    .rx_re,
    .wbyte,
    .led_value,
    .tx_word,
    .rx_word,
    .data_out,
    .data_out_ready
  );

  word_ram u_ram (
    .clk,
    .rst_n,
    .ram,
    .rdata,
    .rready
  );

  io_regs u_io (
    .clk,
    .rst_n,
    .led_we,
    .tx_we,
    .rx_re,
    .wbyte,
    .led,
    .led_value,
    .tx_word,
    .rx_word,
    .tx_go,
    .tx_byte,
    .tx_bsy,
    .rx_go,
    .rx_data,
    .rx_ready
  );

  // serial pins go straight to the UART blocks
  uart_tx u_tx (
    .clk,
    .rst_n,
    .go   (tx_go),
    .data (tx_byte),
    .bsy  (tx_bsy),
    .tx   (uart_tx)
  );

  uart_rx u_rx (
    .clk,
    .rst_n,
    .go         (rx_go),
    .rx         (uart_rx),
    .data       (rx_data),
    .data_ready (rx_ready)
  );

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
//--------------------------------------------------------------------
// 8N1 serial receiver
// with go high it waits for a start bit, then holds data_ready
// with the byte until go drops
//--------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

module uart_rx (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       go,
  input  wire       rx,
  output logic [7:0] data,
  output logic      data_ready
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`RAMIO_CLKS_PER_BIT - 1);
  // middle of the start bit
  localparam logic [CNT_W-1:0] HALF = CNT_W'(`RAMIO_CLKS_PER_BIT / 2 - 1);

  typedef enum logic [2:0] {
    st_idle,
    st_start,
    st_data,
    st_stop,
    st_done
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  // two-flop synchronizer on the line
  logic             rx_meta;
  logic             rx_sync;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= st_idle;
      cnt        <= '0;
      bit_idx    <= '0;
      data_ready <= 1'b0;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        st_idle: begin
          cnt <= '0;
          if (go && !rx_sync) begin
            state <= st_start;
          end
        end
        st_start: begin
          // recheck at mid bit, a short glitch is no start
          if (cnt == HALF) begin
            cnt     <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? st_idle : st_data;
          end
        end
        st_data: begin
          // full period from mid start lands on mid data bit
          if (cnt == LAST) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          // mid stop bit, byte complete
          if (cnt == LAST) begin
            state      <= st_done;
            data_ready <= 1'b1;
          end
        end
        st_done: begin
          cnt <= '0;
          if (!go) begin
            state      <= st_idle;
            data_ready <= 1'b0;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // lsb arrives first, shift in from the top
  always_ff @(posedge clk) begin
    if (state == st_data && cnt == LAST) begin
      data <= {rx_sync, data[7:1]};
    end
  end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
//--------------------------------------------------------------------
// 8N1 serial transmitter
// raise go with data, bsy is high for the ten bits of the frame,
// then drop go to acknowledge and return to idle
//--------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

module uart_tx (
  input  wire       clk,
  input  wire       rst_n,
  input  wire       go,
  input  wire [7:0] data,
  output logic      bsy,
  output logic      tx
);

  localparam int unsigned CNT_W = $clog2(`RAMIO_CLKS_PER_BIT);
  localparam logic [CNT_W-1:0] LAST = CNT_W'(`RAMIO_CLKS_PER_BIT - 1);

  typedef enum logic [1:0] {
    st_idle,
    st_start,
    st_data,
    st_stop
  } state_e;

  state_e           state;
  // cycle within the current bit period
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  // frame byte, lsb on the line
  logic [7:0]       shift;

  // line level from the state, high when idle
  always_comb begin
    case (state)
      st_start: tx = 1'b0;
      st_data:  tx = shift[0];
      default:  tx = 1'b1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state   <= st_idle;
      bsy     <= 1'b0;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= (cnt == LAST) ? '0 : cnt + 1'b1;
      case (state)
        st_idle: begin
          cnt <= '0;
          // start bit goes out in the next cycle
          if (go) begin
            state <= st_start;
            bsy   <= 1'b1;
          end
        end
        st_start: begin
          if (cnt == LAST) begin
            state   <= st_data;
            bit_idx <= '0;
          end
        end
        st_data: begin
          if (cnt == LAST) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= st_stop;
            end
          end
        end
        st_stop: begin
          // bsy drops at the end of the stop bit, then wait for go low
          if (bsy && cnt == LAST) begin
            bsy <= 1'b0;
          end else if (!bsy && !go) begin
            state <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // byte is taken at go, later changes of data do not reach the line
  always_ff @(posedge clk) begin
    if (state == st_idle && go) begin
      shift <= data;
    end else if (state == st_data && cnt == LAST) begin
      shift <= shift >> 1;
    end
  end

endmodule

`default_nettype wire

//--- hw/io_regs.sv
//--------------------------------------------------------------------
// LED register and the UART transmit and receive mailboxes
// runs the go/bsy handshake toward uart_tx and the go/data_ready
// acknowledge toward uart_rx
//--------------------------------------------------------------------
`default_nettype none

module io_regs (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   led_we,
  input  wire                   tx_we,
  input  wire                   rx_re,
  input  wire ramio_pkg::byte_t wbyte,
  output logic [3:0]            led,
  output logic [3:0]            led_value,
  output ramio_pkg::word_t      tx_word,
  output ramio_pkg::word_t      rx_word,
  output logic                  tx_go,
  output ramio_pkg::byte_t      tx_byte,
  input  wire                   tx_bsy,
  output logic                  rx_go,
  input  wire ramio_pkg::byte_t rx_data,
  input  wire                   rx_ready
);

  // set in the cycle after tx_go rises
  // uart_tx has not raised bsy yet then
  logic tx_wait;

  assign led_value = led;
  assign tx_byte   = tx_word[7:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      // LEDs are active low, all off
      led     <= 4'b1111;
      tx_word <= '1;
      tx_go   <= 1'b0;
      tx_wait <= 1'b0;
      rx_word <= '1;
      rx_go   <= 1'b1;
    end else begin
      tx_wait <= 1'b0;

      //----------------------------------------------------------------
      // receive mailbox
      //----------------------------------------------------------------
      // a read empties the mailbox, it wins over a new byte
      if (rx_re) begin
        rx_word <= '1;
      end else if (rx_go && rx_ready) begin
        // overwrites an unread byte
        rx_word <= {24'h000000, rx_data};
        rx_go   <= 1'b0;
      end

      // go is low for one cycle only, which acknowledges data_ready
      if (!rx_go) begin
        rx_go <= 1'b1;
      end

      //----------------------------------------------------------------
      // transmit mailbox
      //----------------------------------------------------------------
      // frame done: drop go and show idle again
      if (tx_go && !tx_bsy && !tx_wait) begin
        tx_go   <= 1'b0;
        tx_word <= '1;
      end

      // a new byte starts a frame
      // while busy it only changes the shown byte
      if (tx_we) begin
        tx_word <= {24'h000000, wbyte};
        tx_go   <= 1'b1;
        tx_wait <= 1'b1;
      end

      // LEDs take the low nibble
      if (led_we) begin
        led <= wbyte[3:0];
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/word_ram.sv
//--------------------------------------------------------------------
// on-chip word RAM with byte write enables and a registered read
// rready follows en by one cycle
//--------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

module word_ram (
  input  wire                     clk,
  input  wire                     rst_n,
  input  wire ramio_pkg::ram_req_t ram,
  output ramio_pkg::word_t        rdata,
  output logic                    rready
);

  localparam int unsigned DEPTH = 2 ** `RAMIO_RAM_ADDR_BITS;

  ramio_pkg::word_t mem [DEPTH];

  // storage and read port
  always_ff @(posedge clk) begin
    if (ram.en) begin
      for (int b = 0; b < $bits(ramio_pkg::byte_en_t); b++) begin
        if (ram.wen[b]) begin
          mem[ram.index][8*b +: 8] <= ram.wdata[8*b +: 8];
        end
      end
      // read returns the word as it was before this edge
      rdata <= mem[ram.index];
    end
  end

  // ready one cycle after an enabled access, low once en drops
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rready <= 1'b0;
    end else begin
      rready <= ram.en;
    end
  end

endmodule

`default_nettype wire

//--- hw/lane_align.sv
//--------------------------------------------------------------------
// address decode and byte lane alignment of a processor request
// steers stores into RAM lanes or I/O strobes, and extracts and
// extends load data; purely combinational
//--------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

module lane_align (
  input  wire                    enable,
  input  wire ramio_pkg::mem_req_t req,
  output ramio_pkg::ram_req_t    ram,
  input  wire ramio_pkg::word_t  rdata,
  input  wire                    rready,
  output logic                   led_we,
  output logic                   tx_we,
  output logic                   rx_re,
  output ramio_pkg::byte_t       wbyte,
  input  wire [3:0]              led_value,
  input  wire ramio_pkg::word_t  tx_word,
  input  wire ramio_pkg::word_t  rx_word,
  output ramio_pkg::word_t       data_out,
  output logic                   data_out_ready
);

  logic             is_led;
  logic             is_tx;
  logic             is_rx;
  logic             is_io;
  logic             is_load;
  logic             is_store;
  logic             ram_sel;
  ramio_pkg::byte_t lane_byte;
  logic [15:0]      lane_half;

  //--------------------------------------------------------------------
  // address decode, the only one in the design
  //--------------------------------------------------------------------
  assign is_led   = req.addr == `RAMIO_ADDR_LED;
  assign is_tx    = req.addr == `RAMIO_ADDR_UART_OUT;
  assign is_rx    = req.addr == `RAMIO_ADDR_UART_IN;
  assign is_io    = is_led | is_tx | is_rx;
  assign is_load  = req.load.size != ramio_pkg::size_none;
  assign is_store = req.store != ramio_pkg::size_none;
  // anything outside the three I/O words is RAM
  assign ram_sel  = enable && !is_io && (is_load || is_store);

  // I/O strobes, any store size takes the low byte
  assign wbyte  = req.data[7:0];
  // skip the LED write when the nibble would not change
  assign led_we = enable && is_led && is_store && (wbyte[3:0] != led_value);
  assign tx_we  = enable && is_tx && is_store;
  // reading the receive mailbox empties it
  assign rx_re  = enable && is_rx && is_load;

  //--------------------------------------------------------------------
  // store lanes
  //--------------------------------------------------------------------
  always_comb begin
    ram       = '0;
    ram.en    = ram_sel;
    // word index from the bits above the byte offset
    ram.index = req.addr[`RAMIO_RAM_ADDR_BITS+1:2];
    if (ram_sel) begin
      case (req.store)
        ramio_pkg::size_byte: begin
          // data on every lane, the enable picks one
          ram.wen   = 4'b0001 << req.addr[1:0];
          ram.wdata = {4{req.data[7:0]}};
        end
        ramio_pkg::size_half: begin
          // misaligned half leaves wen at zero
          if (!req.addr[0]) begin
            ram.wen = req.addr[1] ? 4'b1100 : 4'b0011;
          end
          ram.wdata = {2{req.data[15:0]}};
        end
        ramio_pkg::size_word: begin
          ram.wen   = 4'b1111;
          ram.wdata = req.data;
        end
        default: ;
      endcase
    end
  end

  //--------------------------------------------------------------------
  // load extraction
  //--------------------------------------------------------------------
  assign lane_byte = rdata[{req.addr[1:0], 3'b000} +: 8];
  assign lane_half = rdata[{req.addr[1], 4'b0000} +: 16];

  always_comb begin
    data_out = '0;
    if (enable && is_load) begin
      if (is_tx) begin
        data_out = tx_word;
      end else if (is_rx) begin
        data_out = rx_word;
      end else if (!is_led) begin
        case (req.load.size)
          ramio_pkg::size_byte: begin
            data_out = {{24{req.load.sign & lane_byte[7]}}, lane_byte};
          end
          ramio_pkg::size_half: begin
            // misaligned half reads as zero
            if (!req.addr[0]) begin
              data_out = {{16{req.load.sign & lane_half[15]}}, lane_half};
            end
          end
          ramio_pkg::size_word: data_out = rdata;
          default: ;
        endcase
      end
    end
  end

  // I/O answers at once, RAM after its registered read
  assign data_out_ready = enable && (is_io || rready);

endmodule

`default_nettype wire

//--- hw/ramio_pkg.sv
//--------------------------------------------------------------------
// shared types of the ramio bridge: data widths, access size and
// the request structs passed between the processor, lane alignment
// and the word RAM
//--------------------------------------------------------------------
`default_nettype none

`include "ramio_consts.svh"

package ramio_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;
  typedef logic [7:0] byte_t;
  // one enable per byte lane
  typedef logic [3:0] byte_en_t;
  typedef logic [`RAMIO_RAM_ADDR_BITS-1:0] ram_index_t;

  // size_none means no access of that kind
  typedef enum logic [1:0] {
    size_none,
    size_byte,
    size_half,
    size_word
  } access_size_e;

  // sign set means sign extend a byte or half word load
  typedef struct packed {
    logic         sign;
    access_size_e size;
  } load_kind_t;

  // processor request, held until data_out_ready
  typedef struct packed {
    load_kind_t   load;
    access_size_e store;
    addr_t        addr;
    word_t        data;
  } mem_req_t;

  // word access toward the RAM, wen all zero for a read
  typedef struct packed {
    logic       en;
    ram_index_t index;
    byte_en_t   wen;
    word_t      wdata;
  } ram_req_t;

endpackage

`default_nettype wire

//--- hw/ramio_consts.svh
//--------------------------------------------------------------------
// address map, RAM depth and UART bit timing for the ramio bridge
// include after `default_nettype in any file that needs a constant
//--------------------------------------------------------------------
`ifndef RAMIO_CONSTS_SVH
`define RAMIO_CONSTS_SVH

// I/O window at the very top of the address space
// four LEDs in the low nibble, 0 lights a LED
`define RAMIO_ADDR_LED 32'hffff_fffc
// reads the byte being sent, all ones when idle
`define RAMIO_ADDR_UART_OUT 32'hffff_fff8
// reads the last received byte, all ones when empty
`define RAMIO_ADDR_UART_IN 32'hffff_fff4

// word index width of the on-chip RAM, 256 words
`define RAMIO_RAM_ADDR_BITS 8

// clock cycles per UART bit
// kept small so a frame is only 80 cycles in simulation
`define RAMIO_CLKS_PER_BIT 8

`endif
